// ==== dv/dram_model.sv ====
// behavioral two-rank DRAM that answers RAS/CAS/WE and monitors refresh order
`timescale 1ns/1ps

module dram_model (
	input  logic        fclk,
	input  logic [9:0]  ra,
	input  logic [15:0] rd_out,
	input  logic        rd_oe,
	input  logic        rwe_n,
	input  logic        rucas_n,
	input  logic        rlcas_n,
	input  logic        rras0_n,
	input  logic        rras1_n,
	output logic [15:0] rd_in,
	output logic        proto_err
);

	logic [15:0] mem [0:65535];
	logic [7:0] row = '0;
	logic rank = 1'b0;
	logic ras_prev = 1'b0;
	logic ucas_prev = 1'b1;
	logic lcas_prev = 1'b1;
	logic ras_low;

	// known contents before any write
	function automatic logic [7:0] fill_byte(input logic [16:0] ba);
		return ba[7:0] ^ ba[15:8] ^ {5'b00000, ba[16:14]};
	endfunction

	initial
	begin
		for (int i = 0; i < 65536; i++)
			mem[i] = {fill_byte({i[15:0], 1'b1}), fill_byte({i[15:0], 1'b0})};
	end

	assign ras_low = !rras0_n || !rras1_n;
	assign rd_in = mem[{rank, row, ra[6:0]}];

	always @(posedge fclk)
	begin
		proto_err <= 1'b0;
		if (ras_low && !ras_prev)
		begin
			if (!ucas_prev && !lcas_prev)
			begin
				// CAS before RAS refresh
				if (rras0_n || rras1_n || !rwe_n)
				begin
					$display("dram_model: refresh did not bring both RAS low with WE high");
					proto_err <= 1'b1;
				end
			end
			else if (!ucas_prev || !lcas_prev)
			begin
				$display("dram_model: only one CAS was low when RAS fell");
				proto_err <= 1'b1;
			end
			else
			begin
				row  <= ra[7:0];
				rank <= !rras1_n;
			end
		end
		if ((!rucas_n || !rlcas_n) && ucas_prev && lcas_prev && !ras_low &&
			!(!rucas_n && !rlcas_n))
		begin
			$display("dram_model: a single CAS fell with no RAS active");
			proto_err <= 1'b1;
		end
		if (ras_low && !rwe_n && rd_oe)
		begin
			if (!rucas_n)
				mem[{rank, row, ra[6:0]}][15:8] <= rd_out[15:8];
			if (!rlcas_n)
				mem[{rank, row, ra[6:0]}][7:0] <= rd_out[7:0];
		end
		ras_prev  <= ras_low;
		ucas_prev <= rucas_n;
		lcas_prev <= rlcas_n;
	end

endmodule

// ==== dv/tb_zbus.sv ====
// testbench top for the Z80 bus bridge: clock, reset, bus cycles and random stimulus
`timescale 1ns/1ps

module tb_zbus;

	localparam int n_ops = 400 + 71 + 40 + 20 + 20;
	localparam int timeout_limit = n_ops * 40 + 500;

	logic fclk;
	logic rst_n;
	logic mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n;
	logic [15:0] a;
	logic [7:0] d_in;
	logic [7:0] d_out;
	logic d_oe, csrom, romoe_n;
	logic [9:0] ra;
	logic [15:0] rd_out;
	logic [15:0] rd_in;
	logic rd_oe, rwe_n, rucas_n, rlcas_n, rras0_n, rras1_n;
	logic proto_err;
	int test_num;
	logic test_done;
	logic run_done;
	int err_total;
	int cycle_cnt = 0;
	logic [15:0] lfsr = 16'd36498;
	logic [15:0] addrs [0:199];
	logic [15:0] v;
	logic [15:0] w;

	zbus_top u_zbus_top (
		.fclk(fclk), .rst_n(rst_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .m1_n(m1_n), .rfsh_n(rfsh_n), .a(a), .d_in(d_in), .d_out(d_out),
		.d_oe(d_oe), .csrom(csrom), .romoe_n(romoe_n), .ra(ra), .rd_out(rd_out),
		.rd_oe(rd_oe), .rd_in(rd_in), .rwe_n(rwe_n), .rucas_n(rucas_n),
		.rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n)
	);

	dram_model u_dram_model (
		.fclk(fclk), .ra(ra), .rd_out(rd_out), .rd_oe(rd_oe), .rwe_n(rwe_n),
		.rucas_n(rucas_n), .rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n),
		.rd_in(rd_in), .proto_err(proto_err)
	);

	zbus_checker u_checker (
		.fclk(fclk), .rst_n(rst_n), .mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n),
		.wr_n(wr_n), .rfsh_n(rfsh_n), .a(a), .d_in(d_in), .d_out(d_out), .d_oe(d_oe),
		.csrom(csrom), .romoe_n(romoe_n), .rd_oe(rd_oe), .rwe_n(rwe_n),
		.rucas_n(rucas_n), .rlcas_n(rlcas_n), .rras0_n(rras0_n), .rras1_n(rras1_n),
		.proto_err(proto_err), .test_num(test_num), .test_done(test_done),
		.run_done(run_done), .err_total(err_total)
	);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = !fclk;
	end

	always @(posedge fclk)
	begin
		cycle_cnt++;
		if (cycle_cnt > timeout_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", timeout_limit);
			$display("TEST FAIL");
			$finish;
		end
	end

	// taps 16, 14, 13, 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_step(lfsr);
			val = {val[14:0], lfsr[0]};
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge fclk);
		#2;
	endtask

	task automatic mem_read(input logic [15:0] addr);
		a = addr;
		wait_cycles(1);
		mreq_n = 1'b0;
		rd_n = 1'b0;
		wait_cycles(10);
		rd_n = 1'b1;
		wait_cycles(1);
		mreq_n = 1'b1;
		wait_cycles(6);
	endtask

	task automatic mem_write(input logic [15:0] addr, input logic [7:0] data);
		a = addr;
		d_in = data;
		wait_cycles(1);
		mreq_n = 1'b0;
		wr_n = 1'b0;
		wait_cycles(10);
		wr_n = 1'b1;
		wait_cycles(1);
		mreq_n = 1'b1;
		wait_cycles(6);
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		a = addr;
		d_in = data;
		wait_cycles(1);
		iorq_n = 1'b0;
		wr_n = 1'b0;
		wait_cycles(10);
		wr_n = 1'b1;
		wait_cycles(1);
		iorq_n = 1'b1;
		wait_cycles(6);
	endtask

	task automatic refresh_cycle(input logic [15:0] addr);
		a = addr;
		wait_cycles(1);
		mreq_n = 1'b0;
		rfsh_n = 1'b0;
		wait_cycles(10);
		mreq_n = 1'b1;
		rfsh_n = 1'b1;
		wait_cycles(6);
	endtask

	task automatic finish_test(input int n);
		test_num = n;
		test_done = 1'b1;
		wait_cycles(1);
		test_done = 1'b0;
	endtask

	// random DRAM address, ROM window moved up to 0x4000
	task automatic dram_addr(output logic [15:0] addr);
		take_bits(16, addr);
		if (addr[15:14] == 2'b00)
			addr[14] = 1'b1;
	endtask

	initial
	begin
		rst_n = 1'b0;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n} = 6'b111111;
		a = '0;
		d_in = '0;
		test_num = 1;
		test_done = 1'b0;
		run_done = 1'b0;
		repeat (8) @(posedge fclk);
		#2;
		rst_n = 1'b1;
		wait_cycles(3);
		finish_test(1);

		for (int i = 0; i < 200; i++)
		begin
			dram_addr(addrs[i]);
			take_bits(8, v);
			mem_write(addrs[i], v[7:0]);
		end
		for (int i = 0; i < 200; i++)
			mem_read(addrs[i]);
		finish_test(2);

		for (int p = 0; p < 6; p++)
		begin
			take_bits(11, v);
			io_write({v[10:3], 8'hFD}, {5'b00000, v[2:0]});
			for (int k = 0; k < 4; k++)
			begin
				take_bits(14, addrs[k]);
				take_bits(8, v);
				mem_write(16'hC000 | addrs[k], v[7:0]);
			end
			for (int k = 0; k < 4; k++)
				mem_read(16'hC000 | addrs[k]);
		end
		for (int k = 0; k < 8; k++)
		begin
			take_bits(14, addrs[k]);
			take_bits(8, v);
			mem_write(16'h4000 | addrs[k], v[7:0]);
		end
		io_write(16'h00FD, 8'h05);
		for (int k = 0; k < 8; k++)
			mem_read(16'hC000 | addrs[k]);
		finish_test(3);

		for (int i = 0; i < 40; i++)
		begin
			take_bits(14, w);
			mem_read(w);
		end
		finish_test(4);

		for (int i = 0; i < 20; i++)
		begin
			take_bits(16, w);
			refresh_cycle(w);
		end
		finish_test(5);

		for (int i = 0; i < 20; i++)
		begin
			dram_addr(w);
			mem_read(w);
		end
		finish_test(6);

		run_done = 1'b1;
		wait_cycles(1);
		run_done = 1'b0;
		wait_cycles(1);
		if (err_total == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// ==== dv/zbus_checker.sv ====
// bridge checker that models memory and paging and compares reads and pins
`timescale 1ns/1ps
`include "zbus_defs.svh"

module zbus_checker (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        rfsh_n,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	input  logic [7:0]  d_out,
	input  logic        d_oe,
	input  logic        csrom,
	input  logic        romoe_n,
	input  logic        rd_oe,
	input  logic        rwe_n,
	input  logic        rucas_n,
	input  logic        rlcas_n,
	input  logic        rras0_n,
	input  logic        rras1_n,
	input  logic        proto_err,
	input  int          test_num,
	input  logic        test_done,
	input  logic        run_done,
	output int          err_total
);

	logic [7:0] ref_mem [0:131071];
	logic [2:0] page;
	logic prev_rd_n;
	logic prev_wr_n;
	logic prev_rfsh_n;
	logic ref_seen;
	int high_cnt;
	int checks;
	int test_start_err;
	zbus_pkg::zbus_addr_u av;

	assign av = a;

	function automatic logic [7:0] fill_byte(input logic [16:0] ba);
		return ba[7:0] ^ ba[15:8] ^ {5'b00000, ba[16:14]};
	endfunction

	// Z80 address to DRAM byte address by the memory map
	function automatic logic [16:0] map_addr(input zbus_pkg::zbus_addr_u x, input logic [2:0] pg);
		case (x.mem.window)
			2'd1:    return {`ZBUS_PAGE_4000, x.mem.offset};
			2'd2:    return {`ZBUS_PAGE_8000, x.mem.offset};
			default: return {pg, x.mem.offset};
		endcase
	endfunction

	function automatic string test_name(input int n);
		case (n)
			1:       return "reset state";
			2:       return "random DRAM write and read";
			3:       return "paging port";
			4:       return "ROM reads";
			5:       return "refresh order";
			default: return "d_oe window";
		endcase
	endfunction

	task automatic pin_check(input string sig, input logic exp, input logic act);
		checks++;
		if (exp !== act)
		begin
			err_total++;
			$display("Fail t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
		end
	endtask

	task automatic byte_check(input string sig, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (exp !== act)
		begin
			err_total++;
			$display("Fail t=%0t %s expected %0h actual %0h", $time, sig, exp, act);
		end
	endtask

	initial
	begin
		for (int i = 0; i < 131072; i++)
			ref_mem[i] = fill_byte(17'(i));
	end

	always @(posedge fclk)
	begin
		if (!rst_n)
		begin
			err_total = 0;
			checks = 0;
			test_start_err = 0;
			page = 3'd0;
			high_cnt = 100;
			ref_seen = 1'b0;
		end
		else
		begin
			if (!rd_n)
				high_cnt = 0;
			else if (high_cnt < 100)
				high_cnt++;
			// data must be on the bus when the read ends
			if (rd_n && !prev_rd_n && !mreq_n)
			begin
				if (a <= `ZBUS_ROM_TOP)
				begin
					pin_check("csrom", 1'b1, csrom);
					pin_check("romoe_n", 1'b0, romoe_n);
				end
				else
				begin
					pin_check("d_oe", 1'b1, d_oe);
					byte_check("d_out", ref_mem[map_addr(av, page)], d_out);
				end
			end
			if (wr_n && !prev_wr_n)
			begin
				if (!mreq_n && a > `ZBUS_ROM_TOP)
					ref_mem[map_addr(av, page)] = d_in;
				else if (!iorq_n && av.io.port == `ZBUS_PAGE_PORT)
					page = d_in[2:0];
			end
			if (!mreq_n && !rd_n && rfsh_n && a <= `ZBUS_ROM_TOP)
			begin
				pin_check("d_oe", 1'b0, d_oe);
				pin_check("rras0_n", 1'b1, rras0_n);
				pin_check("rras1_n", 1'b1, rras1_n);
			end
			// refresh must be CAS before RAS on both ranks
			if (!mreq_n && !rfsh_n)
			begin
				if ((!rras0_n || !rras1_n) && (rucas_n || rlcas_n))
				begin
					err_total++;
					$display("RAS was low without both CAS lines during a refresh at %0t",
						$time);
				end
				if (!rras0_n && !rras1_n && !rucas_n && !rlcas_n)
					ref_seen = 1'b1;
			end
			if (rfsh_n && !prev_rfsh_n)
			begin
				checks++;
				if (!ref_seen)
				begin
					err_total++;
					$display("refresh cycle ending at %0t never had both CAS and RAS low",
						$time);
				end
				ref_seen = 1'b0;
			end
			if (d_oe && high_cnt > 3)
			begin
				err_total++;
				$display("d_oe still high at %0t although the read has ended", $time);
			end
			if (proto_err)
				err_total++;
			if (test_done)
			begin
				if (test_num == 1)
				begin
					pin_check("rras0_n", 1'b1, rras0_n);
					pin_check("rras1_n", 1'b1, rras1_n);
					pin_check("rucas_n", 1'b1, rucas_n);
					pin_check("rlcas_n", 1'b1, rlcas_n);
					pin_check("rwe_n", 1'b1, rwe_n);
					pin_check("romoe_n", 1'b1, romoe_n);
					pin_check("csrom", 1'b0, csrom);
					pin_check("d_oe", 1'b0, d_oe);
					pin_check("rd_oe", 1'b0, rd_oe);
				end
				$display("test %0d %s: %s", test_num, test_name(test_num),
					(err_total == test_start_err) ? "ok" : "errors");
				test_start_err = err_total;
			end
			if (run_done)
				$display("checks %0d, errors %0d", checks, err_total);
		end
		prev_rd_n = rd_n;
		prev_wr_n = wr_n;
		prev_rfsh_n = rfsh_n;
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the zbus bridge simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_zbus -f zbus_top.f -o sim_zbus
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sim_zbus > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" sim.log; then
	exit 1
fi
exit 0

// ==== source/dram_sequencer.sv ====
// DRAM sequencer: RAS/CAS/WE timing for read, write and CAS-before-RAS refresh
`timescale 1ns/1ps
`include "zbus_defs.svh"

module dram_sequencer (
	input  logic                 fclk,
	input  logic                 rst_n,
	input  zbus_pkg::zbus_req_t  req,
	input  logic                 req_valid,
	output logic [9:0]           ra,
	output logic [15:0]          rd_out,
	output logic                 rd_oe,
	output logic                 rwe_n,
	output logic                 rucas_n,
	output logic                 rlcas_n,
	output logic                 rras0_n,
	output logic                 rras1_n,
	output logic                 busy,
	output logic                 rdata_valid,
	output logic                 lane
);

	typedef enum logic [1:0] {
		st_idle,
		st_ras,
		st_cas,
		st_pre
	} state_e;

	state_e state;
	logic [2:0] cnt;
	logic is_ref;
	logic col_sel;
	logic start;
	zbus_pkg::dram_cmd_t new_cmd;
	zbus_pkg::dram_cmd_t cmd;
	logic [7:0] wdata;

	// byte address split: rank, row, column, lane
	always_comb
	begin
		new_cmd.rank  = req.addr[16];
		new_cmd.row   = {2'b00, req.addr[15:8]};
		new_cmd.col   = {3'b000, req.addr[7:1]};
		new_cmd.lane  = req.addr[0];
		new_cmd.write = (req.kind == zbus_pkg::kind_dram_wr);
	end

	// requests during a sequence are dropped
	assign start = req_valid && !busy && (req.kind == zbus_pkg::kind_dram_rd ||
		req.kind == zbus_pkg::kind_dram_wr || req.kind == zbus_pkg::kind_refresh);

	always_ff @(posedge fclk)
	begin
		if (start)
		begin
			cmd   <= new_cmd;
			wdata <= req.wdata;
		end
	end

	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state   <= st_idle;
			cnt     <= '0;
			is_ref  <= 1'b0;
			col_sel <= 1'b0;
			rras0_n <= 1'b1;
			rras1_n <= 1'b1;
			rucas_n <= 1'b1;
			rlcas_n <= 1'b1;
			rwe_n   <= 1'b1;
			rd_oe   <= 1'b0;
		end
		else
		begin
			case (state)
				st_idle:
					if (start)
					begin
						state   <= st_ras;
						cnt     <= '0;
						col_sel <= 1'b0;
						is_ref  <= (req.kind == zbus_pkg::kind_refresh);
						if (req.kind == zbus_pkg::kind_refresh)
						begin
							// refresh opens with CAS
							rucas_n <= 1'b0;
							rlcas_n <= 1'b0;
						end
						else
						begin
							rras0_n <= new_cmd.rank;
							rras1_n <= !new_cmd.rank;
							rwe_n   <= !new_cmd.write;
							rd_oe   <= new_cmd.write;
						end
					end
				st_ras:
				begin
					cnt <= cnt + 3'd1;
					// both ranks, one cycle behind CAS
					if (is_ref)
					begin
						rras0_n <= 1'b0;
						rras1_n <= 1'b0;
					end
					if (cnt == 3'(`ZBUS_RAS_TO_CAS - 1))
					begin
						state   <= st_cas;
						cnt     <= '0;
						col_sel <= 1'b1;
						if (!is_ref)
						begin
							// writes strobe only their lane
							rucas_n <= cmd.write && !cmd.lane;
							rlcas_n <= cmd.write && cmd.lane;
						end
					end
				end
				st_cas:
				begin
					cnt <= cnt + 3'd1;
					if (cnt == 3'(`ZBUS_CAS_WIDTH - 1))
					begin
						state   <= st_pre;
						cnt     <= '0;
						col_sel <= 1'b0;
						rras0_n <= 1'b1;
						rras1_n <= 1'b1;
						rucas_n <= 1'b1;
						rlcas_n <= 1'b1;
						rwe_n   <= 1'b1;
						rd_oe   <= 1'b0;
					end
				end
				default:
				begin
					cnt <= cnt + 3'd1;
					if (cnt == 3'(`ZBUS_PRECHARGE - 1))
						state <= st_idle;
				end
			endcase
		end
	end

	assign ra     = col_sel ? cmd.col : cmd.row;
	assign rd_out = {wdata, wdata};
	assign lane   = cmd.lane;
	assign busy   = (state != st_idle);

	// last CAS cycle of a read, data is on rd_in
	assign rdata_valid = (state == st_cas) && (cnt == 3'(`ZBUS_CAS_WIDTH - 1)) &&
		!cmd.write && !is_ref;

endmodule

// ==== source/zbus_decode.sv ====
// Z80 bus decoder: strobe synchronizer, cycle classifier and page register
`timescale 1ns/1ps
`include "zbus_defs.svh"

module zbus_decode (
	input  logic                 fclk,
	input  logic                 rst_n,
	input  logic                 mreq_n,
	input  logic                 iorq_n,
	input  logic                 rd_n,
	input  logic                 wr_n,
	input  logic                 m1_n,
	input  logic                 rfsh_n,
	input  logic [15:0]          a,
	input  logic [7:0]           d_in,
	output zbus_pkg::zbus_req_t  req,
	output logic                 req_valid,
	output logic                 rd_active,
	output logic                 csrom,
	output logic                 romoe_n
);

	logic [5:0] sync1;
	logic [5:0] sync2;
	logic mreq_s, iorq_s, rd_s, wr_s, m1_s, rfsh_s;
	zbus_pkg::zbus_addr_u addr_u;
	zbus_pkg::zbus_kind_e nxt_kind;
	logic [2:0] page_reg;
	logic [2:0] page;
	logic cyc_hit;
	logic bus_idle;
	logic armed;
	logic fire;
	logic rom_rd;

	// two-stage synchronizer, strobes idle high
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			sync1 <= '1;
			sync2 <= '1;
		end
		else
		begin
			sync1 <= {mreq_n, iorq_n, rd_n, wr_n, m1_n, rfsh_n};
			sync2 <= sync1;
		end
	end

	assign {mreq_s, iorq_s, rd_s, wr_s, m1_s, rfsh_s} = sync2;
	assign addr_u = a;

	// window to DRAM page
	always_comb
	begin
		case (addr_u.mem.window)
			2'd1:    page = `ZBUS_PAGE_4000;
			2'd2:    page = `ZBUS_PAGE_8000;
			default: page = page_reg;
		endcase
	end

	// refresh wins over everything, M1 with IORQ is an interrupt ack
	always_comb
	begin
		nxt_kind = zbus_pkg::kind_none;
		if (!mreq_s && !rfsh_s)
			nxt_kind = zbus_pkg::kind_refresh;
		else if (!mreq_s && !rd_s)
			nxt_kind = (a <= `ZBUS_ROM_TOP) ? zbus_pkg::kind_rom_rd : zbus_pkg::kind_dram_rd;
		else if (!mreq_s && !wr_s)
			nxt_kind = (a <= `ZBUS_ROM_TOP) ? zbus_pkg::kind_none : zbus_pkg::kind_dram_wr;
		else if (!iorq_s && !wr_s && m1_s && addr_u.io.port == `ZBUS_PAGE_PORT)
			nxt_kind = zbus_pkg::kind_port_wr;
	end

	assign cyc_hit  = (!mreq_s && (!rfsh_s || !rd_s || !wr_s)) || (!iorq_s && !wr_s);
	assign bus_idle = mreq_s && iorq_s && rd_s && wr_s && rfsh_s;

	// one event per bus cycle, re-armed once every strobe is back high
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			armed <= 1'b1;
			fire  <= 1'b0;
		end
		else
		begin
			fire <= armed && cyc_hit;
			if (armed && cyc_hit)
				armed <= 1'b0;
			else if (bus_idle)
				armed <= 1'b1;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (armed && cyc_hit)
		begin
			req.kind    <= nxt_kind;
			req.addr    <= {page, addr_u.mem.offset};
			req.wdata   <= d_in;
			req.rom_sel <= (nxt_kind == zbus_pkg::kind_rom_rd);
		end
	end

	// paging port takes effect one cycle after the event
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			page_reg <= 3'd0;
		else if (fire && req.kind == zbus_pkg::kind_port_wr)
			page_reg <= req.wdata[2:0];
	end

	assign req_valid = fire && req.kind != zbus_pkg::kind_none &&
		req.kind != zbus_pkg::kind_port_wr;

	assign rd_active = !rd_s;

	assign rom_rd  = !mreq_s && !rd_s && rfsh_s && (a <= `ZBUS_ROM_TOP);
	assign csrom   = rom_rd;
	assign romoe_n = !rom_rd;

endmodule

// ==== source/zbus_defs.svh ====
// zbus bridge constants: memory map limits, paging port and DRAM phase lengths
`ifndef ZBUS_DEFS_SVH
`define ZBUS_DEFS_SVH

// last address served by the ROM
`define ZBUS_ROM_TOP 16'h3FFF

// low byte of the paging port
`define ZBUS_PAGE_PORT 8'hFD

// fixed DRAM pages behind 0x4000 and 0x8000
`define ZBUS_PAGE_4000 3'd5
`define ZBUS_PAGE_8000 3'd2

// DRAM phase lengths, in fclk cycles
`define ZBUS_RAS_TO_CAS 2
`define ZBUS_CAS_WIDTH 2
`define ZBUS_PRECHARGE 2

`endif

// ==== source/zbus_pkg.sv ====
// zbus bridge types: address views, decoded bus request and DRAM command
package zbus_pkg;

	// one Z80 address, seen as memory or as I/O
	typedef union packed {
		struct packed {
			logic [1:0]  window;
			logic [13:0] offset;
		} mem;
		struct packed {
			logic [7:0] high;
			logic [7:0] port;
		} io;
	} zbus_addr_u;

	typedef enum logic [2:0] {
		kind_none,
		kind_rom_rd,
		kind_dram_rd,
		kind_dram_wr,
		kind_port_wr,
		kind_refresh
	} zbus_kind_e;

	// byte address is {page, offset}
	typedef struct packed {
		zbus_kind_e  kind;
		logic [16:0] addr;
		logic [7:0]  wdata;
		logic        rom_sel;
	} zbus_req_t;

	typedef struct packed {
		logic       rank;
		logic [9:0] row;
		logic [9:0] col;
		logic       lane;
		logic       write;
	} dram_cmd_t;

endpackage

// ==== source/zbus_readback.sv ====
// read data return: latches the DRAM word lane and drives it onto the Z80 bus
`timescale 1ns/1ps

module zbus_readback (
	input  logic        fclk,
	input  logic        rst_n,
	input  logic        rdata_valid,
	input  logic        lane,
	input  logic        rd_active,
	input  logic [15:0] rd_in,
	output logic [7:0]  d_out,
	output logic        d_oe
);

	logic [7:0] lane_byte;

	// odd addresses live in the upper half
	assign lane_byte = lane ? rd_in[15:8] : rd_in[7:0];

	always_ff @(posedge fclk)
	begin
		if (rdata_valid)
			d_out <= lane_byte;
	end

	// held until the Z80 ends its read
	always_ff @(posedge fclk or negedge rst_n)
	begin
		if (!rst_n)
			d_oe <= 1'b0;
		else if (!rd_active)
			d_oe <= 1'b0;
		else if (rdata_valid)
			d_oe <= 1'b1;
	end

endmodule

// ==== source/zbus_top.sv ====
// Z80 to DRAM/ROM bridge top level
`timescale 1ns/1ps

module zbus_top (
	input  logic        fclk,
	input  logic        rst_n,

	// z80
	input  logic        mreq_n,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	input  logic        m1_n,
	input  logic        rfsh_n,
	input  logic [15:0] a,
	input  logic [7:0]  d_in,
	output logic [7:0]  d_out,
	output logic        d_oe,

	// rom
	output logic        csrom,
	output logic        romoe_n,

	// dram
	output logic [9:0]  ra,
	output logic [15:0] rd_out,
	output logic        rd_oe,
	input  logic [15:0] rd_in,
	output logic        rwe_n,
	output logic        rucas_n,
	output logic        rlcas_n,
	output logic        rras0_n,
	output logic        rras1_n
);

	zbus_pkg::zbus_req_t req;
	logic req_valid;
	logic rd_active;
	logic rdata_valid;
	logic lane;

	zbus_decode u_decode (
		.fclk      (fclk),
		.rst_n     (rst_n),
		.mreq_n    (mreq_n),
		.iorq_n    (iorq_n),
		.rd_n      (rd_n),
		.wr_n      (wr_n),
		.m1_n      (m1_n),
		.rfsh_n    (rfsh_n),
		.a         (a),
		.d_in      (d_in),
		.req       (req),
		.req_valid (req_valid),
		.rd_active (rd_active),
		.csrom     (csrom),
		.romoe_n   (romoe_n)
	);

	dram_sequencer u_dram (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.req         (req),
		.req_valid   (req_valid),
		.ra          (ra),
		.rd_out      (rd_out),
		.rd_oe       (rd_oe),
		.rwe_n       (rwe_n),
		.rucas_n     (rucas_n),
		.rlcas_n     (rlcas_n),
		.rras0_n     (rras0_n),
		.rras1_n     (rras1_n),
		.busy        (),
		.rdata_valid (rdata_valid),
		.lane        (lane)
	);

	zbus_readback u_readback (
		.fclk        (fclk),
		.rst_n       (rst_n),
		.rdata_valid (rdata_valid),
		.lane        (lane),
		.rd_active   (rd_active),
		.rd_in       (rd_in),
		.d_out       (d_out),
		.d_oe        (d_oe)
	);

endmodule

// ==== zbus_top.f ====
+incdir+source
source/zbus_pkg.sv
source/zbus_decode.sv
source/dram_sequencer.sv
source/zbus_readback.sv
source/zbus_top.sv
dv/dram_model.sv
dv/zbus_checker.sv
dv/tb_zbus.sv
